//--- design/fpu_pkg.sv
package fpu_pkg;

    // ============================
    // Opcodes
    // ============================

    typedef enum logic [7:0] {
        OP_NOP    = 8'h00,
        OP_FLD    = 8'h20,  // Push from data_in
        OP_FST    = 8'h21,  // ST(0) to data_out
        OP_FSTP   = 8'h22,  // ST(0) to data_out, then pop
        OP_FXCH   = 8'h23,  // Swap ST(0) and ST(i)
        OP_FILD16 = 8'h30,
        OP_FILD32 = 8'h31,
        OP_FCLEX  = 8'hF3
    } fpu_op_e;

    // ============================
    // Extended real format
    // ============================

    typedef struct packed {
        logic        sign;
        logic [14:0] exponent;
        logic        int_bit;   // Explicit integer bit
        logic [62:0] fraction;
    } ext_fields_t;

    typedef union packed {
        logic [79:0] raw;
        ext_fields_t f;
    } ext_real_u;

    typedef enum logic [1:0] {
        TAG_VALID   = 2'b00,
        TAG_ZERO    = 2'b01,
        TAG_SPECIAL = 2'b10,
        TAG_EMPTY   = 2'b11
    } tag_e;

    // One stack operation per commit
    typedef struct packed {
        logic        push;
        logic        pop;
        logic        write_st0;
        logic        exchange;
        logic [2:0]  index;     // i of ST(i)
        ext_real_u   wdata;
    } stack_cmd_t;

    typedef struct packed {
        logic overflow;
        logic underflow;
    } stack_fault_t;

    localparam int          EXP_BIAS        = 16383;
    localparam logic [79:0] REAL_INDEFINITE = 80'hFFFF_C000_0000_0000_0000;
    localparam logic [15:0] CW_DEFAULT      = 16'h037F;  // All masked

    // Status word layout
    localparam int SW_BUSY    = 15;
    localparam int SW_TOP_HI  = 13;
    localparam int SW_TOP_LO  = 11;
    localparam int SW_C1      = 9;
    localparam int SW_ES      = 7;
    localparam int SW_SF      = 6;
    localparam int SW_EXC_MSB = 5;  // PE UE OE ZE DE IE
    localparam int SW_IE      = 0;

    // Control word masks
    localparam int CW_MASK_MSB = 5;
    localparam int CW_IM       = 0;

endpackage

//--- design/fpu_register_stack.sv
`timescale 1ns/1ps

module fpu_register_stack (
    input  logic                 clk,
    input  logic                 reset,
    input  fpu_pkg::stack_cmd_t  cmd,
    output fpu_pkg::ext_real_u   st0,
    output fpu_pkg::ext_real_u   sti,
    output logic [2:0]           top,
    output logic [15:0]          tag_word,
    output fpu_pkg::stack_fault_t fault
);
    import fpu_pkg::*;

    logic [79:0] regs [8];   // Physical registers
    tag_e        tags [8];
    logic [2:0]  push_slot;
    logic [2:0]  sti_slot;
    logic        cmd_ok;
    logic        do_push;
    logic        do_pop;
    logic        do_write;
    logic        do_xchg;

    function automatic tag_e tag_of(ext_real_u v);
        return (v.f.exponent == '0 && v.f.fraction == '0) ? TAG_ZERO : TAG_VALID;
    endfunction

    assign push_slot = top - 3'd1;        // Stack grows downward
    assign sti_slot  = top + cmd.index;

    assign st0 = ext_real_u'(regs[top]);
    assign sti = ext_real_u'(regs[sti_slot]);

    // ============================
    // Fault detection
    // ============================

    always_comb begin
        fault = '0;
        fault.overflow  = cmd.push && (tags[push_slot] != TAG_EMPTY);
        fault.underflow = ((cmd.pop || cmd.write_st0 || cmd.exchange)
                           && (tags[top] == TAG_EMPTY))
                          || (cmd.exchange && (tags[sti_slot] == TAG_EMPTY));
    end

    // A faulting command leaves the stack untouched
    assign cmd_ok   = !(fault.overflow || fault.underflow);
    assign do_push  = cmd.push && cmd_ok;
    assign do_pop   = cmd.pop && cmd_ok;
    assign do_write = cmd.write_st0 && cmd_ok;
    assign do_xchg  = cmd.exchange && cmd_ok;

    // ============================
    // TOP and tags
    // ============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            top <= 3'd0;
            for (int r = 0; r < 8; r++) begin
                tags[r] <= TAG_EMPTY;
            end
        end else if (do_push) begin
            top             <= push_slot;
            tags[push_slot] <= tag_of(cmd.wdata);
        end else if (do_pop) begin
            tags[top] <= TAG_EMPTY;
            top       <= top + 3'd1;
        end else if (do_write) begin
            tags[top] <= tag_of(cmd.wdata);
        end else if (do_xchg) begin
            tags[top]      <= tags[sti_slot];
            tags[sti_slot] <= tags[top];
        end
    end

    // Register contents
    always_ff @(posedge clk) begin
        if (do_push) begin
            regs[push_slot] <= cmd.wdata.raw;
        end else if (do_write) begin
            regs[top] <= cmd.wdata.raw;
        end else if (do_xchg) begin
            regs[top]      <= cmd.wdata.raw;  // Carries old ST(i)
            regs[sti_slot] <= st0.raw;
        end
    end

    always_comb begin
        tag_word = '0;
        for (int r = 0; r < 8; r++) begin
            tag_word[2*r +: 2] = tags[r];
        end
    end

endmodule

//--- design/fpu_int_loader.sv
`timescale 1ns/1ps

module fpu_int_loader (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               wide,    // 1 for 32-bit source
    input  logic [31:0]        value,
    output fpu_pkg::ext_real_u result
);
    import fpu_pkg::*;

    logic [31:0] ext_value;
    logic        neg;
    logic [31:0] mag;
    logic [4:0]  msb;
    logic [63:0] norm;
    ext_real_u   conv;

    assign ext_value = wide ? value : {{16{value[15]}}, value[15:0]};
    assign neg       = ext_value[31];
    assign mag       = neg ? (~ext_value + 32'd1) : ext_value;  // 2^31 still fits

    // Position of the leading one
    always_comb begin
        msb = 5'd0;
        for (int b = 0; b < 32; b++) begin
            if (mag[b]) begin
                msb = 5'(b);
            end
        end
    end

    assign norm = {mag, 32'd0} << (5'd31 - msb);

    always_comb begin
        conv.raw = '0;  // Positive zero
        if (mag != '0) begin
            conv.f.sign     = neg;
            conv.f.exponent = 15'(EXP_BIAS + int'(msb));
            conv.f.int_bit  = norm[63];
            conv.f.fraction = norm[62:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else if (start) begin
            result <= conv;
        end
    end

endmodule

//--- design/fpu_status_control.sv
`timescale 1ns/1ps

module fpu_status_control #(
    parameter logic [15:0] CW_RESET_VALUE = fpu_pkg::CW_DEFAULT
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [15:0]           control_in,
    input  logic                  control_write,
    input  logic [2:0]            top,
    input  logic                  busy,
    input  logic                  commit,
    input  fpu_pkg::stack_fault_t fault,
    input  logic                  clear_exc,
    output logic [15:0]           status_word,
    output logic [15:0]           control_word,
    output logic                  error
);
    import fpu_pkg::*;

    logic [SW_EXC_MSB:0] exc_q;  // Sticky exception flags
    logic                sf_q;
    logic                c1_q;
    logic                es;
    logic                any_fault;

    assign any_fault = fault.overflow || fault.underflow;

    // ============================
    // Control word
    // ============================

    // Rounding and precision fields are kept but not used
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            control_word <= CW_RESET_VALUE;
        end else if (control_write) begin
            control_word <= control_in;
        end
    end

    // ============================
    // Status word
    // ============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exc_q <= '0;
            sf_q  <= 1'b0;
            c1_q  <= 1'b0;
        end else if (clear_exc) begin
            exc_q <= '0;
            sf_q  <= 1'b0;
            c1_q  <= 1'b0;
        end else if (commit && any_fault) begin
            exc_q[SW_IE] <= 1'b1;            // Stack fault is an invalid op
            sf_q         <= 1'b1;
            c1_q         <= fault.overflow;  // 1 up, 0 down
        end
    end

    // Summary of unmasked exceptions
    assign es = |(exc_q & ~control_word[CW_MASK_MSB:0]);

    always_comb begin
        status_word                       = '0;
        status_word[SW_BUSY]              = busy;
        status_word[SW_TOP_HI:SW_TOP_LO]  = top;
        status_word[SW_C1]                = c1_q;
        status_word[SW_ES]                = es;
        status_word[SW_SF]                = sf_q;
        status_word[SW_EXC_MSB:0]         = exc_q;
    end

    assign error = es;

endmodule

//--- design/fpu_sequencer.sv
`timescale 1ns/1ps

module fpu_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [7:0]            instruction,
    input  logic [2:0]            stack_index,
    input  logic                  execute,
    input  logic [79:0]           data_in,
    input  logic [31:0]           int_data_in,
    input  fpu_pkg::ext_real_u    st0,
    input  fpu_pkg::ext_real_u    sti,
    input  fpu_pkg::stack_fault_t fault,
    input  fpu_pkg::ext_real_u    loader_result,
    output logic                  ready,
    output logic                  busy,
    output logic [79:0]           data_out,
    output fpu_pkg::stack_cmd_t   stack_cmd,
    output logic                  loader_start,
    output logic                  loader_wide,
    output logic [31:0]           loader_value,
    output logic                  commit,
    output logic                  clear_exc
);
    import fpu_pkg::*;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_LOAD   = 2'd1;  // Loader converts here
    localparam logic [1:0] S_COMMIT = 2'd2;  // Stack and status update at end

    logic [1:0]  state;
    fpu_op_e     op_q;
    logic [2:0]  idx_q;
    logic [79:0] data_q;
    logic [31:0] int_q;
    logic        accept;
    logic        is_fild;
    logic        is_store;

    assign accept   = execute && ready;
    assign is_fild  = (op_q == OP_FILD16) || (op_q == OP_FILD32);
    assign is_store = (op_q == OP_FST) || (op_q == OP_FSTP);

    // ============================
    // Instruction FSM
    // ============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= S_IDLE;
            ready    <= 1'b1;
            op_q     <= OP_NOP;
            idx_q    <= 3'd0;
            data_out <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        op_q  <= fpu_op_e'(instruction);
                        idx_q <= stack_index;
                        ready <= 1'b0;
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    state <= S_COMMIT;
                end
                S_COMMIT: begin
                    if (is_store) begin
                        data_out <= fault.underflow ? REAL_INDEFINITE : st0.raw;
                    end
                    ready <= 1'b1;
                    state <= S_IDLE;
                end
                default: begin
                    ready <= 1'b1;
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Operands sampled on the accepting edge
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= data_in;
            int_q  <= int_data_in;
        end
    end

    assign loader_start = (state == S_LOAD) && is_fild;
    assign loader_wide  = (op_q == OP_FILD32);
    assign loader_value = int_q;

    // ============================
    // Stack command
    // ============================

    always_comb begin
        stack_cmd           = '0;
        stack_cmd.index     = idx_q;
        stack_cmd.wdata.raw = data_q;
        if (state == S_COMMIT) begin
            case (op_q)
                OP_FLD: begin
                    stack_cmd.push = 1'b1;
                end
                OP_FILD16, OP_FILD32: begin
                    stack_cmd.push  = 1'b1;
                    stack_cmd.wdata = loader_result;
                end
                OP_FST: begin
                    stack_cmd.write_st0 = 1'b1;   // Rewrite ST(0) in place
                    stack_cmd.wdata     = st0;
                end
                OP_FSTP: begin
                    stack_cmd.pop = 1'b1;
                end
                OP_FXCH: begin
                    stack_cmd.exchange = 1'b1;
                    stack_cmd.wdata    = sti;     // New ST(0)
                end
                default: begin
                    // NOP and FCLEX leave the stack alone
                end
            endcase
        end
    end

    assign commit    = (state == S_COMMIT);
    assign clear_exc = commit && (op_q == OP_FCLEX);
    assign busy      = (state != S_IDLE);

endmodule

//--- design/fpu_core.sv
`timescale 1ns/1ps

module fpu_core #(
    parameter logic [15:0] CW_RESET_VALUE = fpu_pkg::CW_DEFAULT
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  instruction,
    input  logic [2:0]  stack_index,
    input  logic        execute,
    output logic        ready,
    output logic        error,
    input  logic [79:0] data_in,
    output logic [79:0] data_out,
    input  logic [31:0] int_data_in,  // FILD16 uses [15:0]
    input  logic [15:0] control_in,
    input  logic        control_write,
    output logic [15:0] status_out,
    output logic [15:0] control_out,
    output logic [15:0] tag_word_out
);
    import fpu_pkg::*;

    stack_cmd_t   stack_cmd;
    stack_fault_t fault;
    ext_real_u    st0;
    ext_real_u    sti;
    ext_real_u    loader_result;
    logic [2:0]   top;
    logic         busy;
    logic         loader_start;
    logic         loader_wide;
    logic [31:0]  loader_value;
    logic         commit;
    logic         clear_exc;

    fpu_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .stack_index   (stack_index),
        .execute       (execute),
        .data_in       (data_in),
        .int_data_in   (int_data_in),
        .st0           (st0),
        .sti           (sti),
        .fault         (fault),
        .loader_result (loader_result),
        .ready         (ready),
        .busy          (busy),
        .data_out      (data_out),
        .stack_cmd     (stack_cmd),
        .loader_start  (loader_start),
        .loader_wide   (loader_wide),
        .loader_value  (loader_value),
        .commit        (commit),
        .clear_exc     (clear_exc)
    );

    fpu_register_stack u_stack (
        .clk      (clk),
        .reset    (reset),
        .cmd      (stack_cmd),
        .st0      (st0),
        .sti      (sti),
        .top      (top),
        .tag_word (tag_word_out),
        .fault    (fault)
    );

    fpu_int_loader u_loader (
        .clk    (clk),
        .reset  (reset),
        .start  (loader_start),
        .wide   (loader_wide),
        .value  (loader_value),
        .result (loader_result)
    );

    fpu_status_control #(
        .CW_RESET_VALUE (CW_RESET_VALUE)
    ) u_status (
        .clk           (clk),
        .reset         (reset),
        .control_in    (control_in),
        .control_write (control_write),
        .top           (top),
        .busy          (busy),
        .commit        (commit),
        .fault         (fault),
        .clear_exc     (clear_exc),
        .status_word   (status_out),
        .control_word  (control_out),
        .error         (error)
    );

endmodule

//--- sim/fpu_core_asserts.sv
`timescale 1ns/1ps

module fpu_core_asserts (
    input logic        clk,
    input logic        reset,
    input logic        execute,
    input logic        ready,
    input logic        error,
    input logic [15:0] status_out,
    input logic [15:0] control_out
);
    import fpu_pkg::*;

    logic accept;
    int   fail_count = 0;  // Failed assertions so far

    assign accept = execute && ready;

    // ============================
    // Handshake
    // ============================

    a_ready_after_reset: assert property (@(posedge clk) $past(reset) && !reset |-> ready)
        else begin
            fail_count++;
            $error("ready low after reset");
        end

    a_ready_drops: assert property (@(posedge clk) disable iff (reset)
        $past(accept) |-> !ready)
        else begin
            fail_count++;
            $error("ready still high after accept");
        end

    // Sampled low at E1 and E2, high again at E3
    a_ready_busy: assert property (@(posedge clk) disable iff (reset)
        $past(accept, 2) |-> !ready)
        else begin
            fail_count++;
            $error("ready returned too early");
        end

    a_ready_returns: assert property (@(posedge clk) disable iff (reset)
        $past(accept, 3) |-> ready)
        else begin
            fail_count++;
            $error("ready did not return after two edges");
        end

    // Stack faults raise only IE, so error needs an unmasked IE
    a_error_source: assert property (@(posedge clk) disable iff (reset)
        error |-> status_out[SW_ES] && status_out[SW_IE] && !control_out[CW_IM])
        else begin
            fail_count++;
            $error("error high without an unmasked invalid-operation flag");
        end

endmodule

//--- sim/tb_fpu_core.sv
`timescale 1ns/1ps

module tb_fpu_core;
    import fpu_pkg::*;

    localparam logic [31:0] SEED          = 32'he993_927e;
    localparam int          READY_TIMEOUT = 20;      // Cycles
    localparam logic [16:0] NO_CW         = '0;
    localparam logic [16:0] CW_UNMASK_IM  = {1'b1, 16'h037E};

    // FILD results from the normalization rule
    localparam logic [79:0] V_M1   = 80'hBFFF_8000_0000_0000_0000;  // -1, leading one at bit 0
    localparam logic [79:0] V_1000 = 80'h4008_FA00_0000_0000_0000;  // Leading one at bit 9
    localparam logic [79:0] V_MAX  = 80'h401D_FFFF_FFFE_0000_0000;  // 2^31-1
    localparam logic [79:0] V_MIN  = 80'hC01E_8000_0000_0000_0000;  // -2^31

    typedef struct packed {
        fpu_op_e     op;
        logic [2:0]  idx;
        logic [79:0] operand;    // data_in, low 32 bits also on int_data_in
        logic [79:0] exp_data;   // Checked for FST and FSTP only
        logic        cw_write;
        logic [15:0] cw_value;
        logic [2:0]  exp_top;
        logic [15:0] exp_tags;
        logic [3:0]  exp_flags;  // SF IE C1 error
    } row_t;

    logic        clk;
    logic        reset;
    logic [7:0]  instruction;
    logic [2:0]  stack_index;
    logic        execute;
    logic        ready;
    logic        error;
    logic [79:0] data_in;
    logic [79:0] data_out;
    logic [31:0] int_data_in;
    logic [15:0] control_in;
    logic        control_write;
    logic [15:0] status_out;
    logic [15:0] control_out;
    logic [15:0] tag_word_out;

    row_t        table_q[$];
    logic [79:0] rnd [5];
    logic [15:0] cw_expected;

    fpu_core DUT (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .stack_index   (stack_index),
        .execute       (execute),
        .ready         (ready),
        .error         (error),
        .data_in       (data_in),
        .data_out      (data_out),
        .int_data_in   (int_data_in),
        .control_in    (control_in),
        .control_write (control_write),
        .status_out    (status_out),
        .control_out   (control_out),
        .tag_word_out  (tag_word_out)
    );

    bind fpu_core fpu_core_asserts u_asserts (
        .clk         (clk),
        .reset       (reset),
        .execute     (execute),
        .ready       (ready),
        .error       (error),
        .status_out  (status_out),
        .control_out (control_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(DUT.u_asserts.fail_count) begin
        if (DUT.u_asserts.fail_count != 0) begin
            $display("Assertion failed in the bound checker");
            $display("ERRORS FOUND");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_value(input string name, input logic [79:0] actual,
                               input logic [79:0] expected);
        if (actual !== expected) begin
            $display("ERR t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready && cycles <= READY_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!ready) begin
            $display("Timeout: ready stayed low for %0d cycles", cycles);
            $display("ERRORS FOUND");
            $fatal(1, "handshake timeout");
        end
    endtask

    function automatic void add_row(input fpu_op_e op, input logic [2:0] idx,
                                    input logic [79:0] operand, input logic [79:0] exp_data,
                                    input logic [16:0] cw, input logic [2:0] exp_top,
                                    input logic [15:0] exp_tags, input logic [3:0] exp_flags);
        row_t r;
        r.op        = op;
        r.idx       = idx;
        r.operand   = operand;
        r.exp_data  = exp_data;
        r.cw_write  = cw[16];
        r.cw_value  = cw[15:0];
        r.exp_top   = exp_top;
        r.exp_tags  = exp_tags;
        r.exp_flags = exp_flags;
        table_q.push_back(r);
    endfunction

    // Issue one instruction and compare the result once ready returns
    task automatic apply_row(input row_t row);
        instruction   = row.op;
        stack_index   = row.idx;
        data_in       = row.operand;
        int_data_in   = row.operand[31:0];
        control_in    = row.cw_value;
        control_write = row.cw_write;
        execute       = 1'b1;
        @(posedge clk);
        #1;
        execute       = 1'b0;
        control_write = 1'b0;
        if (row.cw_write) begin
            cw_expected = row.cw_value;
        end
        wait_ready();
        if (row.op == OP_FST || row.op == OP_FSTP) begin
            check_value("data_out", data_out, row.exp_data);
        end
        check_value("status TOP", 80'(status_out[SW_TOP_HI:SW_TOP_LO]), 80'(row.exp_top));
        check_value("tag_word_out", 80'(tag_word_out), 80'(row.exp_tags));
        check_value("status SF", 80'(status_out[SW_SF]), 80'(row.exp_flags[3]));
        check_value("status IE", 80'(status_out[SW_IE]), 80'(row.exp_flags[2]));
        check_value("status C1", 80'(status_out[SW_C1]), 80'(row.exp_flags[1]));
        check_value("status ES", 80'(status_out[SW_ES]), 80'(row.exp_flags[0]));
        check_value("error", 80'(error), 80'(row.exp_flags[0]));
        check_value("status busy", 80'(status_out[SW_BUSY]), 80'(1'b0));
        check_value("control_out", 80'(control_out), 80'(cw_expected));
    endtask

    initial begin
        void'($urandom(SEED));
        reset         = 1'b1;
        instruction   = OP_NOP;
        stack_index   = 3'd0;
        execute       = 1'b0;
        data_in       = '0;
        int_data_in   = '0;
        control_in    = '0;
        control_write = 1'b0;
        cw_expected   = CW_DEFAULT;
        for (int k = 0; k < 5; k++) begin
            rnd[k]     = 80'({$urandom(), $urandom(), $urandom()});
            rnd[k][64] = 1'b1;  // Keep exponent nonzero so the tag is valid
        end

        // ============================
        // Stimulus table
        // ============================
        add_row(OP_FST,    3'd0, '0,     REAL_INDEFINITE, NO_CW, 3'd0, 16'hFFFF, 4'b1100);
        add_row(OP_FCLEX,  3'd0, '0,     '0,     NO_CW, 3'd0, 16'hFFFF, 4'b0000);
        add_row(OP_FLD,    3'd0, rnd[0], '0,     NO_CW, 3'd7, 16'h3FFF, 4'b0000);
        add_row(OP_FLD,    3'd0, rnd[1], '0,     NO_CW, 3'd6, 16'h0FFF, 4'b0000);
        add_row(OP_FLD,    3'd0, rnd[2], '0,     NO_CW, 3'd5, 16'h03FF, 4'b0000);
        add_row(OP_FST,    3'd0, '0,     rnd[2], NO_CW, 3'd5, 16'h03FF, 4'b0000);
        add_row(OP_FXCH,   3'd2, '0,     '0,     NO_CW, 3'd5, 16'h03FF, 4'b0000);
        add_row(OP_FST,    3'd0, '0,     rnd[0], NO_CW, 3'd5, 16'h03FF, 4'b0000);
        add_row(OP_FXCH,   3'd2, '0,     '0,     NO_CW, 3'd5, 16'h03FF, 4'b0000);
        add_row(OP_FST,    3'd0, '0,     rnd[2], NO_CW, 3'd5, 16'h03FF, 4'b0000);  // Old ST(2)
        add_row(OP_FSTP,   3'd0, '0,     rnd[2], NO_CW, 3'd6, 16'h0FFF, 4'b0000);
        add_row(OP_FST,    3'd0, '0,     rnd[1], NO_CW, 3'd6, 16'h0FFF, 4'b0000);
        add_row(OP_FILD16, 3'd0, 80'hABCD_FFFF, '0, NO_CW, 3'd5, 16'h03FF, 4'b0000);
        add_row(OP_FST,    3'd0, '0,     V_M1,   NO_CW, 3'd5, 16'h03FF, 4'b0000);
        add_row(OP_FILD16, 3'd0, 80'h0001_0000, '0, NO_CW, 3'd4, 16'h01FF, 4'b0000);
        add_row(OP_FST,    3'd0, '0,     '0,     NO_CW, 3'd4, 16'h01FF, 4'b0000);
        add_row(OP_FILD16, 3'd0, 80'h03E8, '0,   NO_CW, 3'd3, 16'h013F, 4'b0000);
        add_row(OP_FST,    3'd0, '0,     V_1000, NO_CW, 3'd3, 16'h013F, 4'b0000);
        add_row(OP_FILD32, 3'd0, 80'h7FFF_FFFF, '0, NO_CW, 3'd2, 16'h010F, 4'b0000);
        add_row(OP_FST,    3'd0, '0,     V_MAX,  NO_CW, 3'd2, 16'h010F, 4'b0000);
        add_row(OP_FILD32, 3'd0, 80'h8000_0000, '0, NO_CW, 3'd1, 16'h0103, 4'b0000);
        add_row(OP_FST,    3'd0, '0,     V_MIN,  NO_CW, 3'd1, 16'h0103, 4'b0000);
        add_row(OP_FLD,    3'd0, rnd[3], '0,     NO_CW, 3'd0, 16'h0100, 4'b0000);
        add_row(OP_FST,    3'd0, '0,     rnd[3], NO_CW, 3'd0, 16'h0100, 4'b0000);
        add_row(OP_FLD,    3'd0, rnd[4], '0,     NO_CW, 3'd0, 16'h0100, 4'b1110);  // Ninth push
        add_row(OP_FCLEX,  3'd0, '0,     '0,     NO_CW, 3'd0, 16'h0100, 4'b0000);
        add_row(OP_NOP,    3'd0, '0,     '0,     CW_UNMASK_IM, 3'd0, 16'h0100, 4'b0000);
        add_row(OP_FLD,    3'd0, rnd[4], '0,     NO_CW, 3'd0, 16'h0100, 4'b1111);
        add_row(OP_FCLEX,  3'd0, '0,     '0,     NO_CW, 3'd0, 16'h0100, 4'b0000);

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // Reset state
        check_value("ready", 80'(ready), 80'(1'b1));
        check_value("error", 80'(error), 80'(1'b0));
        check_value("data_out", data_out, '0);
        check_value("control_out", 80'(control_out), 80'(CW_DEFAULT));
        check_value("status_out", 80'(status_out), '0);
        check_value("tag_word_out", 80'(tag_word_out), 80'(16'hFFFF));

        foreach (table_q[n]) begin
            apply_row(table_q[n]);
        end

        if (DUT.u_asserts.fail_count != 0) begin
            $display("Assertion failed in the bound checker");
            $display("ERRORS FOUND");
            $fatal(1, "assertion failure");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- compile.f
design/fpu_pkg.sv
design/fpu_register_stack.sv
design/fpu_int_loader.sv
design/fpu_status_control.sv
design/fpu_sequencer.sv
design/fpu_core.sv
sim/fpu_core_asserts.sv
sim/tb_fpu_core.sv

//--- Makefile
# Verilator build and run for the FPU register-stack testbench

VERILATOR ?= verilator
TOP       ?= tb_fpu_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
